/* Bender.yml */
package:
  name: krv_periph

sources:
  - verilog/ahb_pkg.sv
  - verilog/soc_map_pkg.sv
  - verilog/ahb_reg_port.sv
  - verilog/ahb_decoder.sv
  - verilog/core_timer.sv
  - verilog/kplic.sv
  - verilog/gpio.sv
  - verilog/krv_periph.sv
  - target: test
    files:
      - test/krv_periph_properties.sv
      - test/tb_krv_periph.sv

/* list.f */
verilog/ahb_pkg.sv
verilog/soc_map_pkg.sv
verilog/ahb_reg_port.sv
verilog/ahb_decoder.sv
verilog/core_timer.sv
verilog/kplic.sv
verilog/gpio.sv
verilog/krv_periph.sv
test/krv_periph_properties.sv
test/tb_krv_periph.sv

/* test/krv_periph_properties.sv */
// Bus and interrupt properties of the peripheral top
// Error responses only after unmapped address phases, kplic output
// consistent with pending and enable, timer interrupt quiet in reset

`timescale 1ns/10ps

module krv_periph_properties #(
	parameter int INT_NUM = 8
) (
	input logic               hclk,
	input logic               rst_n,
	input ahb_pkg::ahb_req_t  req,
	input ahb_pkg::ahb_rsp_t  rsp,
	input logic [INT_NUM-1:0] pending,
	input logic [INT_NUM-1:0] enable,
	input logic               timer_irq,
	input logic               plic_irq
);

	logic        xfer;
	logic        unmapped;
	int unsigned fail_cnt = 0;

	assign xfer     = (req.trans == ahb_pkg::nonseq) || (req.trans == ahb_pkg::seq);
	// Only slave fields 0 to 2 are mapped
	assign unmapped = req.addr[soc_map_pkg::SLAVE_SEL_LSB +: soc_map_pkg::SLAVE_SEL_W] > 4'd2;

	error_after_unmapped: assert property (@(posedge hclk) disable iff (!rst_n)
		rsp.resp == ahb_pkg::error |-> $past(xfer && unmapped))
		else begin
			fail_cnt++;
			$error("error response without an unmapped address phase before it");
		end

	plic_irq_matches: assert property (@(posedge hclk) disable iff (!rst_n)
		plic_irq == |(pending & enable))
		else begin
			fail_cnt++;
			$error("plic_irq differs from the OR of pending and enable");
		end

	// Sampled mid cycle, after the first reset edge
	timer_irq_in_reset: assert property (@(negedge hclk) !rst_n |-> !timer_irq)
		else begin
			fail_cnt++;
			$error("timer_irq high during reset");
		end

endmodule

bind krv_periph krv_periph_properties #(.INT_NUM(INT_NUM)) i_props (
	.hclk      (hclk),
	.rst_n     (rst_n),
	.req       (req),
	.rsp       (rsp),
	.pending   (u_kplic.pending),
	.enable    (u_kplic.enable),
	.timer_irq (timer_irq),
	.plic_irq  (plic_irq)
);

/* test/tb_krv_periph.sv */
// Testbench for the peripheral subsystem
// Acts as the bus master and walks a table of bus transfers, pin drives
// and interrupt checks through the timer, the kplic and the gpio port

`timescale 1ns/10ps

module tb_krv_periph;

	localparam int TICK_DIV    = 4;
	localparam int INT_NUM     = 8;
	localparam int GPIO_W      = 8;
	localparam int IRQ_TIMEOUT = 200;

	// Slave field values of the memory map
	localparam int f_timer    = 0;
	localparam int f_kplic    = 1;
	localparam int f_gpio     = 2;
	localparam int f_unmapped = 5;

	typedef enum {op_write, op_read, op_wait_irq, op_drive, op_level, op_idle} op_e;
	typedef enum {
		pin_none, pin_timer_irq, pin_plic_irq, pin_gpio_out, pin_gpio_in, pin_ext_irq
	} pin_e;

	typedef struct {
		string           name;
		op_e             op;
		pin_e            pin;
		ahb_pkg::addr_t  addr;
		ahb_pkg::data_t  wdata;
		ahb_pkg::data_t  exp;
		ahb_pkg::hresp_e resp;
	} entry_t;

	logic               hclk;
	logic               rst_n;
	ahb_pkg::ahb_req_t  req;
	ahb_pkg::data_t     hwdata;
	ahb_pkg::ahb_rsp_t  rsp;
	logic [INT_NUM-1:0] ext_irq;
	logic [GPIO_W-1:0]  gpio_in;
	logic [GPIO_W-1:0]  gpio_out;
	logic               timer_irq;
	logic               plic_irq;

	entry_t            steps[$];
	ahb_pkg::ahb_rsp_t got;
	ahb_pkg::data_t    gpio_val;
	ahb_pkg::data_t    pin_val;

	krv_periph #(
		.TICK_DIV (TICK_DIV),
		.INT_NUM  (INT_NUM),
		.GPIO_W   (GPIO_W)
	) i_dut (
		.hclk      (hclk),
		.rst_n     (rst_n),
		.req       (req),
		.hwdata    (hwdata),
		.rsp       (rsp),
		.ext_irq   (ext_irq),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out),
		.timer_irq (timer_irq),
		.plic_irq  (plic_irq)
	);

	always #50 hclk = ~hclk;

	function automatic ahb_pkg::addr_t reg_addr(input int field, input int word);
		return ahb_pkg::addr_t'((field << soc_map_pkg::SLAVE_SEL_LSB) | (word << 2));
	endfunction

	function automatic logic pin_level(input pin_e pin);
		case (pin)
			pin_timer_irq: return timer_irq;
			pin_plic_irq:  return plic_irq;
			default:       return 1'bx;
		endcase
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input ahb_pkg::data_t exp,
			input ahb_pkg::data_t act);
		if (act !== exp)
			fail_stop($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_resp(input string name, input ahb_pkg::hresp_e exp,
			input ahb_pkg::hresp_e act);
		if (act !== exp)
			fail_stop($sformatf("mismatch %s: expected %s, actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic make_step(input string name, input op_e op, input pin_e pin,
			input ahb_pkg::addr_t addr, input ahb_pkg::data_t wdata,
			input ahb_pkg::data_t exp, input ahb_pkg::hresp_e resp);
		entry_t e;
		e.name  = name;
		e.op    = op;
		e.pin   = pin;
		e.addr  = addr;
		e.wdata = wdata;
		e.exp   = exp;
		e.resp  = resp;
		steps.push_back(e);
	endtask

	task automatic write_step(input string name, input int field, input int word,
			input ahb_pkg::data_t wdata, input ahb_pkg::hresp_e resp);
		make_step(name, op_write, pin_none, reg_addr(field, word), wdata, '0, resp);
	endtask

	task automatic read_step(input string name, input int field, input int word,
			input ahb_pkg::data_t exp, input ahb_pkg::hresp_e resp);
		make_step(name, op_read, pin_none, reg_addr(field, word), '0, exp, resp);
	endtask

	task automatic pin_step(input string name, input op_e op, input pin_e pin,
			input ahb_pkg::data_t val);
		make_step(name, op, pin, '0, val, val, ahb_pkg::okay);
	endtask

	// Address phase, then data phase; response sampled mid data phase
	task automatic bus_xfer(input ahb_pkg::addr_t addr, input logic write,
			input ahb_pkg::data_t wdata, output ahb_pkg::ahb_rsp_t rsp_got);
		@(posedge hclk);
		req <= '{trans: ahb_pkg::nonseq, addr: addr, write: write};
		@(posedge hclk);
		req    <= '{trans: ahb_pkg::idle, addr: '0, write: 1'b0};
		hwdata <= wdata;
		@(negedge hclk);
		rsp_got = rsp;
	endtask

	task automatic wait_irq(input string name, input pin_e pin);
		int n;
		for (n = 0; n < IRQ_TIMEOUT; n++) begin
			@(negedge hclk);
			if (pin_level(pin) === 1'b1)
				break;
		end
		if (n == IRQ_TIMEOUT)
			fail_stop($sformatf("%s: interrupt line did not rise within %0d cycles", name,
				IRQ_TIMEOUT));
	endtask

	task automatic build_steps();
		pin_step("reset_timer_irq", op_level, pin_timer_irq, 0);
		pin_step("reset_plic_irq", op_level, pin_plic_irq, 0);
		read_step("reset_mtimecmp_lo", f_timer, soc_map_pkg::mtimecmp_lo, '1, ahb_pkg::okay);

		write_step("gpio_out_write", f_gpio, soc_map_pkg::data_out, gpio_val, ahb_pkg::okay);
		pin_step("gpio_out_pins", op_level, pin_gpio_out, gpio_val & ((1 << GPIO_W) - 1));
		read_step("gpio_out_read", f_gpio, soc_map_pkg::data_out,
			gpio_val & ((1 << GPIO_W) - 1), ahb_pkg::okay);
		pin_step("gpio_in_drive", op_drive, pin_gpio_in, pin_val);
		pin_step("gpio_in_settle", op_idle, pin_none, 3);
		read_step("gpio_in_read", f_gpio, soc_map_pkg::data_in,
			pin_val & ((1 << GPIO_W) - 1), ahb_pkg::okay);

		write_step("mtime_lo_clear", f_timer, soc_map_pkg::mtime_lo, 0, ahb_pkg::okay);
		write_step("mtime_hi_clear", f_timer, soc_map_pkg::mtime_hi, 0, ahb_pkg::okay);
		write_step("mtimecmp_hi_set", f_timer, soc_map_pkg::mtimecmp_hi, 0, ahb_pkg::okay);
		write_step("mtimecmp_lo_set", f_timer, soc_map_pkg::mtimecmp_lo, 20, ahb_pkg::okay);
		pin_step("timer_irq_rise", op_wait_irq, pin_timer_irq, 1);
		read_step("mtime_hi_read", f_timer, soc_map_pkg::mtime_hi, 0, ahb_pkg::okay);
		write_step("mtimecmp_hi_max", f_timer, soc_map_pkg::mtimecmp_hi, '1, ahb_pkg::okay);
		pin_step("timer_irq_settle", op_idle, pin_none, 2);
		pin_step("timer_irq_fall", op_level, pin_timer_irq, 0);

		// Sources 3 and 5 enabled, 6 stays masked
		write_step("enable_write", f_kplic, soc_map_pkg::enable, (1 << 3) | (1 << 5),
			ahb_pkg::okay);
		pin_step("ext_irq_high", op_drive, pin_ext_irq, (1 << 3) | (1 << 5) | (1 << 6));
		pin_step("ext_irq_low", op_drive, pin_ext_irq, 0);
		pin_step("plic_irq_rise", op_wait_irq, pin_plic_irq, 1);
		read_step("pending_read", f_kplic, soc_map_pkg::pending,
			(1 << 3) | (1 << 5) | (1 << 6), ahb_pkg::okay);
		read_step("claim_first", f_kplic, soc_map_pkg::claim, 3 + 1, ahb_pkg::okay);
		read_step("claim_second", f_kplic, soc_map_pkg::claim, 5 + 1, ahb_pkg::okay);
		pin_step("plic_irq_fall", op_level, pin_plic_irq, 0);
		read_step("claim_empty", f_kplic, soc_map_pkg::claim, 0, ahb_pkg::okay);
		read_step("pending_masked", f_kplic, soc_map_pkg::pending, 1 << 6, ahb_pkg::okay);

		read_step("unmapped_read", f_unmapped, 0, 0, ahb_pkg::error);
		write_step("unmapped_write", f_unmapped, 0, gpio_val, ahb_pkg::error);
		read_step("timer_after_error", f_timer, soc_map_pkg::mtimecmp_lo, 20, ahb_pkg::okay);
	endtask

	always @(negedge hclk) begin
		if (i_dut.i_props.fail_cnt != 0)
			fail_stop("a bus or interrupt assertion failed");
	end

	initial begin
		hclk    = 1'b0;
		rst_n   = 1'b0;
		req     = '{trans: ahb_pkg::idle, addr: '0, write: 1'b0};
		hwdata  = '0;
		ext_irq = '0;
		gpio_in = '0;

		void'($urandom(32'h64af5449));
		gpio_val = $urandom;
		pin_val  = $urandom;
		build_steps();

		repeat (2) @(posedge hclk);
		rst_n <= 1'b1;

		foreach (steps[i]) begin
			entry_t e;
			e = steps[i];
			case (e.op)
				op_write: begin
					bus_xfer(e.addr, 1'b1, e.wdata, got);
					check_resp(e.name, e.resp, got.resp);
					// An error response carries zero data on writes too
					if (e.resp == ahb_pkg::error)
						check_data(e.name, e.exp, got.rdata);
				end
				op_read: begin
					bus_xfer(e.addr, 1'b0, '0, got);
					check_resp(e.name, e.resp, got.resp);
					check_data(e.name, e.exp, got.rdata);
				end
				op_wait_irq: wait_irq(e.name, e.pin);
				op_drive: begin
					@(posedge hclk);
					if (e.pin == pin_gpio_in)
						gpio_in <= e.wdata[GPIO_W-1:0];
					else
						ext_irq <= e.wdata[INT_NUM-1:0];
				end
				op_level: begin
					@(negedge hclk);
					if (e.pin == pin_gpio_out)
						check_data(e.name, e.exp, ahb_pkg::data_t'(gpio_out));
					else
						check_level(e.name, e.exp[0], pin_level(e.pin));
				end
				default: begin
					for (int n = 0; n < e.wdata; n++)
						@(posedge hclk);
				end
			endcase
		end

		// Let the last data phase end
		@(negedge hclk);
		if (i_dut.i_props.fail_cnt != 0)
			fail_stop("a bus or interrupt assertion failed");
		else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

/* verilog/ahb_decoder.sv */
// AHB slave decoder
// Decodes the slave field of the address into a one-hot select and keeps
// the addressed slave for the data phase, where it picks that slave's
// response. Unmapped addresses get an error response with zero data

`timescale 1ns/10ps

module ahb_decoder (
	input  logic              hclk,
	input  logic              rst_n,
	input  ahb_pkg::ahb_req_t req,
	output logic [2:0]        sel,
	input  ahb_pkg::ahb_rsp_t timer_rsp,
	input  ahb_pkg::ahb_rsp_t kplic_rsp,
	input  ahb_pkg::ahb_rsp_t gpio_rsp,
	output ahb_pkg::ahb_rsp_t rsp
);

	logic [soc_map_pkg::SLAVE_SEL_W-1:0] field;
	soc_map_pkg::slave_e                 slave_d;
	soc_map_pkg::slave_e                 slave_q;
	logic                                xfer;
	logic                                dphase;

	assign field = req.addr[soc_map_pkg::SLAVE_SEL_LSB +: soc_map_pkg::SLAVE_SEL_W];
	assign xfer  = (req.trans == ahb_pkg::nonseq) || (req.trans == ahb_pkg::seq);

	always_comb begin
		case (field)
			4'd0:    slave_d = soc_map_pkg::timer;
			4'd1:    slave_d = soc_map_pkg::kplic;
			4'd2:    slave_d = soc_map_pkg::gpio;
			default: slave_d = soc_map_pkg::none;
		endcase
	end

	// Select bit index equals the slave id
	always_comb begin
		sel = 3'b000;
		if (slave_d != soc_map_pkg::none)
			sel[slave_d] = 1'b1;
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			dphase  <= 1'b0;
			slave_q <= soc_map_pkg::none;
		end else begin
			dphase <= xfer;
			if (xfer)
				slave_q <= slave_d;
		end
	end

	always_comb begin
		rsp = '{rdata: '0, resp: ahb_pkg::okay};
		if (dphase) begin
			case (slave_q)
				soc_map_pkg::timer: rsp = timer_rsp;
				soc_map_pkg::kplic: rsp = kplic_rsp;
				soc_map_pkg::gpio:  rsp = gpio_rsp;
				default:            rsp.resp = ahb_pkg::error;
			endcase
		end
	end

endmodule

/* verilog/ahb_pkg.sv */
// AHB bus types
// Word and address types, transfer and response encodings, and the
// request, response and register access bundles shared by the decoder,
// the register ports and the peripherals

package ahb_pkg;

	typedef logic [31:0] data_t;
	typedef logic [31:0] addr_t;

	typedef enum logic [1:0] {
		idle   = 2'b00,
		busy   = 2'b01,
		nonseq = 2'b10,
		seq    = 2'b11
	} htrans_e;

	typedef enum logic {
		okay  = 1'b0,
		error = 1'b1
	} hresp_e;

	// Address phase from the master
	typedef struct packed {
		htrans_e trans;
		addr_t   addr;
		logic    write;
	} ahb_req_t;

	// Data phase back to the master
	typedef struct packed {
		data_t  rdata;
		hresp_e resp;
	} ahb_rsp_t;

	// One-cycle strobe bundle from a register port to its slave
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic [3:0] offset;
		data_t      wdata;
	} reg_acc_t;

endpackage

/* verilog/ahb_reg_port.sv */
// AHB register port
// Captures the word offset and direction of a selected transfer in its
// address phase and issues a single read or write strobe in the data phase

`timescale 1ns/10ps

module ahb_reg_port (
	input  logic              hclk,
	input  logic              rst_n,
	input  logic              sel,
	input  ahb_pkg::ahb_req_t req,
	input  ahb_pkg::data_t    hwdata,
	output ahb_pkg::reg_acc_t acc
);

	logic       xfer;
	logic       active;
	logic       write_q;
	logic [3:0] offset_q;

	assign xfer = sel && (req.trans == ahb_pkg::nonseq || req.trans == ahb_pkg::seq);

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			write_q <= 1'b0;
		end else begin
			active <= xfer;
			if (xfer)
				write_q <= req.write;
		end
	end

	// Word index within the slave window
	always_ff @(posedge hclk) begin
		if (xfer)
			offset_q <= req.addr[5:2];
	end

	assign acc.wr     = active & write_q;
	assign acc.rd     = active & ~write_q;
	assign acc.offset = offset_q;
	assign acc.wdata  = hwdata;

endmodule

/* verilog/core_timer.sv */
// Machine timer
// Free-running 64-bit mtime advanced by a prescaler, a 64-bit mtimecmp,
// and a registered timer interrupt raised while mtime >= mtimecmp

`timescale 1ns/10ps

module core_timer #(
	parameter int TICK_DIV = 4
) (
	input  logic              hclk,
	input  logic              rst_n,
	input  logic              sel,
	input  ahb_pkg::ahb_req_t req,
	input  ahb_pkg::data_t    hwdata,
	output ahb_pkg::ahb_rsp_t rsp,
	output logic              timer_irq
);

	localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	ahb_pkg::reg_acc_t acc;
	logic [DIV_W-1:0]  div_cnt;
	logic              tick;
	logic [63:0]       mtime;
	logic [63:0]       mtimecmp;

	ahb_reg_port u_reg_port (
		.hclk   (hclk),
		.rst_n  (rst_n),
		.sel    (sel),
		.req    (req),
		.hwdata (hwdata),
		.acc    (acc)
	);

	assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Software write to either half wins over the tick
	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n)
			mtime <= '0;
		else if (acc.wr && acc.offset == soc_map_pkg::mtime_lo)
			mtime[31:0] <= acc.wdata;
		else if (acc.wr && acc.offset == soc_map_pkg::mtime_hi)
			mtime[63:32] <= acc.wdata;
		else if (tick)
			mtime <= mtime + 64'd1;
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (acc.wr) begin
			if (acc.offset == soc_map_pkg::mtimecmp_lo)
				mtimecmp[31:0] <= acc.wdata;
			if (acc.offset == soc_map_pkg::mtimecmp_hi)
				mtimecmp[63:32] <= acc.wdata;
		end
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n)
			timer_irq <= 1'b0;
		else
			timer_irq <= (mtime >= mtimecmp);
	end

	always_comb begin
		rsp.resp = ahb_pkg::okay;
		case (acc.offset)
			soc_map_pkg::mtime_lo:    rsp.rdata = mtime[31:0];
			soc_map_pkg::mtime_hi:    rsp.rdata = mtime[63:32];
			soc_map_pkg::mtimecmp_lo: rsp.rdata = mtimecmp[31:0];
			soc_map_pkg::mtimecmp_hi: rsp.rdata = mtimecmp[63:32];
			default:                  rsp.rdata = '0;
		endcase
	end

endmodule

/* verilog/gpio.sv */
// General-purpose I/O port
// Output data register driving the pins, and a two-flop synchronizer
// that brings the input pins into the bus clock domain

`timescale 1ns/10ps

module gpio #(
	parameter int GPIO_W = 8
) (
	input  logic              hclk,
	input  logic              rst_n,
	input  logic              sel,
	input  ahb_pkg::ahb_req_t req,
	input  ahb_pkg::data_t    hwdata,
	output ahb_pkg::ahb_rsp_t rsp,
	input  logic [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_out
);

	ahb_pkg::reg_acc_t acc;
	logic [GPIO_W-1:0] in_meta;
	logic [GPIO_W-1:0] in_sync;

	ahb_reg_port u_reg_port (
		.hclk   (hclk),
		.rst_n  (rst_n),
		.sel    (sel),
		.req    (req),
		.hwdata (hwdata),
		.acc    (acc)
	);

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			in_meta  <= '0;
			in_sync  <= '0;
			gpio_out <= '0;
		end else begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
			if (acc.wr && acc.offset == soc_map_pkg::data_out)
				gpio_out <= acc.wdata[GPIO_W-1:0];
		end
	end

	always_comb begin
		rsp.resp = ahb_pkg::okay;
		case (acc.offset)
			soc_map_pkg::data_out: rsp.rdata = ahb_pkg::data_t'(gpio_out);
			soc_map_pkg::data_in:  rsp.rdata = ahb_pkg::data_t'(in_sync);
			default:               rsp.rdata = '0;
		endcase
	end

endmodule

/* verilog/kplic.sv */
// Compact platform interrupt controller
// Latches rising edges of the external sources into pending bits, masks
// them with an enable register and hands out the lowest active source on
// a claim read, which also clears that source's pending bit

`timescale 1ns/10ps

module kplic #(
	parameter int INT_NUM = 8
) (
	input  logic               hclk,
	input  logic               rst_n,
	input  logic               sel,
	input  ahb_pkg::ahb_req_t  req,
	input  ahb_pkg::data_t     hwdata,
	output ahb_pkg::ahb_rsp_t  rsp,
	input  logic [INT_NUM-1:0] ext_irq,
	output logic               plic_irq
);

	ahb_pkg::reg_acc_t  acc;
	logic [INT_NUM-1:0] irq_q;
	logic [INT_NUM-1:0] rise;
	logic [INT_NUM-1:0] pending;
	logic [INT_NUM-1:0] enable;
	logic [INT_NUM-1:0] active;
	logic [INT_NUM-1:0] claim_mask;
	logic [INT_NUM-1:0] clr;
	ahb_pkg::data_t     claim_id;

	ahb_reg_port u_reg_port (
		.hclk   (hclk),
		.rst_n  (rst_n),
		.sel    (sel),
		.req    (req),
		.hwdata (hwdata),
		.acc    (acc)
	);

	assign rise     = ext_irq & ~irq_q;
	assign active   = pending & enable;
	assign plic_irq = |active;

	// Scan from the top so the lowest active source is kept
	always_comb begin
		claim_id   = '0;
		claim_mask = '0;
		for (int i = INT_NUM - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_id      = ahb_pkg::data_t'(i + 1);
				claim_mask    = '0;
				claim_mask[i] = 1'b1;
			end
		end
	end

	assign clr = (acc.rd && acc.offset == soc_map_pkg::claim) ? claim_mask : '0;

	// A new edge on the claimed source in the same cycle stays pending
	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n) begin
			irq_q   <= '0;
			pending <= '0;
		end else begin
			irq_q   <= ext_irq;
			pending <= (pending & ~clr) | rise;
		end
	end

	always_ff @(posedge hclk or negedge rst_n) begin
		if (!rst_n)
			enable <= '0;
		else if (acc.wr && acc.offset == soc_map_pkg::enable)
			enable <= acc.wdata[INT_NUM-1:0];
	end

	always_comb begin
		rsp.resp = ahb_pkg::okay;
		case (acc.offset)
			soc_map_pkg::pending: rsp.rdata = ahb_pkg::data_t'(pending);
			soc_map_pkg::enable:  rsp.rdata = ahb_pkg::data_t'(enable);
			soc_map_pkg::claim:   rsp.rdata = claim_id;
			default:              rsp.rdata = '0;
		endcase
	end

endmodule

/* verilog/krv_periph.sv */
// Peripheral subsystem top
// Bus decoder in front of the machine timer, the kplic and the gpio port,
// all on the single bus clock

`timescale 1ns/10ps

module krv_periph #(
	parameter int TICK_DIV = 4,
	parameter int INT_NUM  = 8,
	parameter int GPIO_W   = 8
) (
	input  logic               hclk,
	input  logic               rst_n,
	input  ahb_pkg::ahb_req_t  req,
	input  ahb_pkg::data_t     hwdata,
	output ahb_pkg::ahb_rsp_t  rsp,
	input  logic [INT_NUM-1:0] ext_irq,
	input  logic [GPIO_W-1:0]  gpio_in,
	output logic [GPIO_W-1:0]  gpio_out,
	output logic               timer_irq,
	output logic               plic_irq
);

	logic [2:0]        sel;
	ahb_pkg::ahb_rsp_t timer_rsp;
	ahb_pkg::ahb_rsp_t kplic_rsp;
	ahb_pkg::ahb_rsp_t gpio_rsp;

	ahb_decoder u_decoder (
		.hclk      (hclk),
		.rst_n     (rst_n),
		.req       (req),
		.sel       (sel),
		.timer_rsp (timer_rsp),
		.kplic_rsp (kplic_rsp),
		.gpio_rsp  (gpio_rsp),
		.rsp       (rsp)
	);

	core_timer #(.TICK_DIV(TICK_DIV)) u_core_timer (
		.hclk      (hclk),
		.rst_n     (rst_n),
		.sel       (sel[soc_map_pkg::timer]),
		.req       (req),
		.hwdata    (hwdata),
		.rsp       (timer_rsp),
		.timer_irq (timer_irq)
	);

	kplic #(.INT_NUM(INT_NUM)) u_kplic (
		.hclk     (hclk),
		.rst_n    (rst_n),
		.sel      (sel[soc_map_pkg::kplic]),
		.req      (req),
		.hwdata   (hwdata),
		.rsp      (kplic_rsp),
		.ext_irq  (ext_irq),
		.plic_irq (plic_irq)
	);

	gpio #(.GPIO_W(GPIO_W)) u_gpio (
		.hclk     (hclk),
		.rst_n    (rst_n),
		.sel      (sel[soc_map_pkg::gpio]),
		.req      (req),
		.hwdata   (hwdata),
		.rsp      (gpio_rsp),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out)
	);

endmodule

/* verilog/soc_map_pkg.sv */
// Peripheral memory map
// Slave identifiers, the address field that picks a slave, and the word
// offsets of the registers inside the timer, the kplic and the gpio

package soc_map_pkg;

	typedef enum logic [1:0] {
		timer = 2'd0,
		kplic = 2'd1,
		gpio  = 2'd2,
		none  = 2'd3
	} slave_e;

	// Slave field sits at addr[15:12]
	localparam int SLAVE_SEL_LSB = 12;
	localparam int SLAVE_SEL_W   = 4;

	typedef enum logic [3:0] {
		mtime_lo    = 4'd0,
		mtime_hi    = 4'd1,
		mtimecmp_lo = 4'd2,
		mtimecmp_hi = 4'd3
	} timer_reg_e;

	typedef enum logic [3:0] {
		pending = 4'd0,
		enable  = 4'd1,
		claim   = 4'd2
	} kplic_reg_e;

	typedef enum logic [3:0] {
		data_out = 4'd0,
		data_in  = 4'd1
	} gpio_reg_e;

endpackage
